// ==== design/emesh_pkg.sv ====
package emesh_pkg;

   //##################################################
   // Mesh packet geometry
   //##################################################
   localparam int AW = 32;         // Address width
   localparam int PW = 2*AW + 40;  // Packet width, 104 bits

   // Datamode encodings
   localparam logic [1:0] DOUBLE = 2'b11;  // 64-bit access

   // Request and response share this layout
   // First field is the MSB end, write sits at bit 0
   typedef struct packed {
      logic [AW-1:0] srcaddr;   // Return address, upper data on responses
      logic [AW-1:0] data;      // Lower data word
      logic [AW-1:0] dstaddr;   // Target register address
      logic [4:0]    ctrlmode;  // Passed back untouched
      logic [1:0]    datamode;  // Access size
      logic          write;     // 1 = write, 0 = read
   } emesh_req_t;

endpackage

// ==== design/gpio_pkg.sv ====
package gpio_pkg;

   //##################################################
   // Register map, index is dstaddr[6:3]
   //##################################################
   localparam logic [3:0] REG_OEN    = 4'd0;  // Output enable
   localparam logic [3:0] REG_OUT    = 4'd1;  // Output data, plain load
   localparam logic [3:0] REG_IEN    = 4'd2;  // Input enable
   localparam logic [3:0] REG_IN     = 4'd3;  // Latched input, read only
   localparam logic [3:0] REG_OUTAND = 4'd4;  // Output data AND
   localparam logic [3:0] REG_OUTORR = 4'd5;  // Output data OR
   localparam logic [3:0] REG_OUTXOR = 4'd6;  // Output data XOR
   localparam logic [3:0] REG_IMASK  = 4'd7;  // Interrupt mask

   //##################################################
   // Control register reset values
   //##################################################
   // Pins come up tristated with inputs live
   localparam logic [63:0] OEN_RESET   = 64'h0;
   localparam logic [63:0] OUT_RESET   = 64'h0;
   localparam logic [63:0] IEN_RESET   = {64{1'b1}};  // All inputs on
   localparam logic [63:0] IMASK_RESET = 64'h0;       // Nothing masked

endpackage

// ==== design/reg_access_if.sv ====
// One decoded register access, valid in the access_in cycle
interface reg_access_if;

   logic                     write;     // Write strobe
   logic                     read;      // Read strobe
   logic                     double;    // 64-bit access
   logic [3:0]               index;     // Register index
   logic                     odd;       // Upper 32-bit half select
   logic [63:0]              wdata;     // {srcaddr, data}
   logic [emesh_pkg::AW-1:0] ret_addr;  // Where the response goes
   logic [1:0]               datamode;
   logic [4:0]               ctrlmode;

   modport decoder (
      output write, read, double, index, odd, wdata, ret_addr, datamode, ctrlmode
   );

   modport regfile (
      input write, read, double, index, odd, wdata
   );

   modport readback (
      input read, ret_addr, datamode, ctrlmode
   );

endinterface

// ==== design/emesh_decoder.sv ====
module emesh_decoder (
   input  logic [emesh_pkg::PW-1:0] packet_in,  // Request packet
   input  logic                     access_in,  // Request valid
   reg_access_if.decoder            acc         // Decoded access
);

   emesh_pkg::emesh_req_t req;

   // Field view of the raw packet
   assign req = emesh_pkg::emesh_req_t'(packet_in);

   //##################################################
   // Strobes
   //##################################################
   assign acc.write  = access_in & req.write;
   assign acc.read   = access_in & ~req.write;
   assign acc.double = (req.datamode == emesh_pkg::DOUBLE);

   //##################################################
   // Address fields
   //##################################################
   // 8-byte register stride
   assign acc.index = req.dstaddr[6:3];
   // Word select within a register
   assign acc.odd   = req.dstaddr[2];

   // Srcaddr carries the upper word on a double write
   assign acc.wdata = {req.srcaddr[31:0], req.data[31:0]};

   //##################################################
   // Response routing
   //##################################################
   assign acc.ret_addr = req.srcaddr;   // Reply goes back to sender
   assign acc.datamode = req.datamode;
   assign acc.ctrlmode = req.ctrlmode;  // Echoed as is

endmodule

// ==== design/gpio_input_stage.sv ====
module gpio_input_stage #(
   parameter int N = 24               // Pin count
) (
   input  logic         clk,
   input  logic         nreset,
   input  logic [N-1:0] gpio_in,      // Raw pins, async to clk
   input  logic [N-1:0] ien,          // Input enable
   input  logic [N-1:0] imask,        // 1 = no interrupt from pin
   output logic [N-1:0] gpio_data,    // Synced and enabled pins
   output logic [N-1:0] in_value,     // Input register
   output logic         gpio_irq      // Toggle pulse
);

   logic [N-1:0] sync_q1;    // Metastability stage
   logic [N-1:0] sync_q2;
   logic [N-1:0] edge_data;  // Unmasked input bits
   logic [N-1:0] edge_prev;  // Last cycle's unmasked bits

   //##################################################
   // Synchronizer and input enable
   //##################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= gpio_in;
         sync_q2 <= sync_q1;
      end
   end

   // Gated here too, in case the pad has no enable
   assign gpio_data = sync_q2 & ien;

   //##################################################
   // Input register and toggle detect
   //##################################################
   assign edge_data = in_value & ~imask;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         in_value  <= '0;
         edge_prev <= '0;
         gpio_irq  <= 1'b0;
      end else begin
         in_value  <= gpio_data;
         edge_prev <= edge_data;
         gpio_irq  <= |(edge_data ^ edge_prev);  // Any toggle, either direction
      end
   end

endmodule

// ==== design/gpio_regfile.sv ====
module gpio_regfile #(
   parameter int N = 24                // Pin count
) (
   input  logic          clk,
   input  logic          nreset,
   reg_access_if.regfile acc,          // Decoded access
   input  logic [N-1:0]  in_value,     // From input stage
   output logic [N-1:0]  gpio_out,     // Pin output data
   output logic [N-1:0]  gpio_oen,     // Output enable
   output logic [N-1:0]  ien,          // Input enable
   output logic [N-1:0]  imask,        // Interrupt mask
   output logic [63:0]   read_data     // Registered readback
);

   logic [63:0] oen_reg;
   logic [63:0] out_reg;
   logic [63:0] ien_reg;
   logic [63:0] imask_reg;
   logic [63:0] out_next;   // Output value after the op
   logic        out_hit;    // Any write to the output register
   logic [63:0] in_ext;     // Input register, zero extended
   logic        hi_sel;     // Read upper half

   // Single writes touch only the low word
   function automatic logic [63:0] merge(input logic [63:0] cur,
                                         input logic [63:0] nxt,
                                         input logic        dbl);
      merge = dbl ? nxt : {cur[63:32], nxt[31:0]};
   endfunction

   function automatic logic [31:0] half(input logic [63:0] r, input logic hi);
      half = hi ? r[63:32] : r[31:0];
   endfunction

   //##################################################
   // Output register operations
   //##################################################
   always_comb begin
      out_hit = acc.write;
      case (acc.index)
         gpio_pkg::REG_OUT:    out_next = acc.wdata;
         gpio_pkg::REG_OUTAND: out_next = out_reg & acc.wdata;  // Clear bits
         gpio_pkg::REG_OUTORR: out_next = out_reg | acc.wdata;  // Set bits
         gpio_pkg::REG_OUTXOR: out_next = out_reg ^ acc.wdata;  // Flip bits
         default: begin
            out_next = acc.wdata;
            out_hit  = 1'b0;
         end
      endcase
   end

   //##################################################
   // Control registers
   //##################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         oen_reg   <= gpio_pkg::OEN_RESET;
         out_reg   <= gpio_pkg::OUT_RESET;
         ien_reg   <= gpio_pkg::IEN_RESET;
         imask_reg <= gpio_pkg::IMASK_RESET;
      end else begin
         if (acc.write && acc.index == gpio_pkg::REG_OEN)
            oen_reg <= merge(oen_reg, acc.wdata, acc.double);
         if (out_hit)
            out_reg <= merge(out_reg, out_next, acc.double);
         if (acc.write && acc.index == gpio_pkg::REG_IEN)
            ien_reg <= merge(ien_reg, acc.wdata, acc.double);
         if (acc.write && acc.index == gpio_pkg::REG_IMASK)
            imask_reg <= merge(imask_reg, acc.wdata, acc.double);
      end
   end

   assign gpio_oen = oen_reg[N-1:0];
   assign gpio_out = out_reg[N-1:0];
   assign ien      = ien_reg[N-1:0];
   assign imask    = imask_reg[N-1:0];

   //##################################################
   // Readback
   //##################################################
   assign hi_sel = (N > 32) && acc.odd;  // Upper half only exists past 32 pins
   assign in_ext = 64'(in_value);

   // Held until the next read, so it stays put under wait
   always_ff @(posedge clk) begin
      if (acc.read) begin
         case (acc.index)
            gpio_pkg::REG_OEN:   read_data <= {32'h0, half(oen_reg, hi_sel)};
            gpio_pkg::REG_OUT:   read_data <= {32'h0, half(out_reg, hi_sel)};
            gpio_pkg::REG_IEN:   read_data <= {32'h0, half(ien_reg, hi_sel)};
            gpio_pkg::REG_IN:    read_data <= {32'h0, half(in_ext, hi_sel)};
            gpio_pkg::REG_IMASK: read_data <= {32'h0, half(imask_reg, hi_sel)};
            default:             read_data <= '0;  // Op aliases read zero
         endcase
      end
   end

endmodule

// ==== design/emesh_readback.sv ====
module emesh_readback (
   input  logic                     clk,
   input  logic                     nreset,
   reg_access_if.readback           acc,         // Read strobe and routing
   input  logic [63:0]              read_data,   // From register file
   input  logic                     wait_in,     // Consumer stall
   output logic                     access_out,  // Response valid
   output logic                     wait_out,    // Response held
   output logic [emesh_pkg::PW-1:0] packet_out   // Response packet
);

   logic [emesh_pkg::AW-1:0] dst_q;       // Return address
   logic [1:0]               datamode_q;
   logic [4:0]               ctrlmode_q;
   emesh_pkg::emesh_req_t    rsp;

   //##################################################
   // Response valid
   //##################################################
   // New read sets it, wait_in keeps it
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= acc.read | (access_out & wait_in);
   end

   // Requester must stop while a response is stuck
   assign wait_out = access_out & wait_in;

   // Routing fields, no new read arrives during a hold
   always_ff @(posedge clk) begin
      if (acc.read) begin
         dst_q      <= acc.ret_addr;
         datamode_q <= acc.datamode;
         ctrlmode_q <= acc.ctrlmode;
      end
   end

   //##################################################
   // Response packet
   //##################################################
   always_comb begin
      rsp.write    = 1'b1;              // Response is a write to the sender
      rsp.datamode = datamode_q;
      rsp.ctrlmode = ctrlmode_q;
      rsp.dstaddr  = dst_q;
      rsp.srcaddr  = read_data[63:32];  // Upper word
      rsp.data     = read_data[31:0];
   end

   assign packet_out = rsp;

endmodule

// ==== design/gpio.sv ====
module gpio #(
   parameter int N = 24                         // Pin count, up to 64
) (
   input  logic                     clk,
   input  logic                     nreset,
   // Request side
   input  logic                     access_in,
   input  logic [emesh_pkg::PW-1:0] packet_in,
   output logic                     wait_out,
   // Response side
   output logic                     access_out,
   output logic [emesh_pkg::PW-1:0] packet_out,
   input  logic                     wait_in,
   // Pins
   input  logic [N-1:0]             gpio_in,
   output logic [N-1:0]             gpio_out,
   output logic [N-1:0]             gpio_oen,
   output logic [N-1:0]             gpio_ie,
   output logic [N-1:0]             gpio_data,
   output logic                     gpio_irq
);

   logic [N-1:0] imask;
   logic [N-1:0] in_value;
   logic [63:0]  read_data;

   reg_access_if acc ();

   //##################################################
   // Request decode and registers
   //##################################################
   emesh_decoder i_decoder (.packet_in(packet_in), .access_in(access_in), .acc(acc));

   gpio_regfile #(.N(N)) i_regfile (
      .clk(clk), .nreset(nreset), .acc(acc), .in_value(in_value),
      .gpio_out(gpio_out), .gpio_oen(gpio_oen), .ien(gpio_ie),
      .imask(imask), .read_data(read_data));

   // Pin sampling and interrupt
   gpio_input_stage #(.N(N)) i_input (
      .clk(clk), .nreset(nreset), .gpio_in(gpio_in), .ien(gpio_ie),
      .imask(imask), .gpio_data(gpio_data), .in_value(in_value), .gpio_irq(gpio_irq));

   // Read response
   emesh_readback i_readback (
      .clk(clk), .nreset(nreset), .acc(acc), .read_data(read_data),
      .wait_in(wait_in), .access_out(access_out), .wait_out(wait_out),
      .packet_out(packet_out));

endmodule

// ==== verif/clk_gen.sv ====
module clk_gen #(
   parameter int HALF_NS      = 2,   // 4 ns period
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic nreset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   // Release just after an edge, away from the sampling point
   initial begin
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 nreset = 1'b1;
   end

endmodule

// ==== verif/gpio_props.sv ====
module gpio_props (
   input logic                     clk,
   input logic                     nreset,
   input logic                     read,
   input logic                     wait_in,
   input logic                     access_out,
   input logic                     wait_out,
   input logic [emesh_pkg::PW-1:0] packet_out
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;  // Assertion failures so far

   // Held response must not move
   held_stable: assert property (@(posedge clk) disable iff (!nreset)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else begin
         fail_count++;
         $error("response changed while wait_in was held");
      end

   // wait_out only for a fresh read or a response already stuck
   wait_only_when_held: assert property (@(posedge clk) disable iff (!nreset)
      wait_out |-> ($past(read) || $past(wait_out)))
      else begin
         fail_count++;
         $error("wait_out high with no response held");
      end

   reset_quiet: assert property (@(posedge clk) !nreset |-> !access_out)
      else begin
         fail_count++;
         $error("access_out high during reset");
      end

endmodule

bind emesh_readback gpio_props i_props (
   .clk(clk), .nreset(nreset), .read(acc.read), .wait_in(wait_in),
   .access_out(access_out), .wait_out(wait_out), .packet_out(packet_out));

// ==== verif/tb_gpio.sv ====
module tb_gpio;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N = 24;
   localparam int PW = emesh_pkg::PW;
   localparam int CLK_NS = 4;
   localparam int NUM_OPS = 50;
   localparam int NUM_REG = 12;
   localparam int NUM_IN = 8;
   localparam int NUM_IRQ = 4;
   localparam int NUM_TXN = 3 + NUM_OPS + 2*NUM_REG + 11 + 1 + 2*NUM_IN + 1 + 2*NUM_IRQ + 1;
   localparam int TIMEOUT_NS = (NUM_TXN*40 + 200) * CLK_NS;

   logic clk, nreset, access_in, wait_in, access_out, wait_out, gpio_irq;
   logic [PW-1:0] packet_in, packet_out;
   logic [N-1:0] gpio_in, gpio_out, gpio_oen, gpio_ie, gpio_data;
   logic [63:0] oen_m, out_m, ien_m, imask_m;  // Register model
   logic [PW-1:0] exp_q [$];                    // Pending read responses
   int rsp_count = 0;

   clk_gen i_clk (.clk(clk), .nreset(nreset));

   gpio #(.N(N)) i_dut (
      .clk(clk), .nreset(nreset), .access_in(access_in), .packet_in(packet_in),
      .wait_out(wait_out), .access_out(access_out), .packet_out(packet_out),
      .wait_in(wait_in), .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oen(gpio_oen),
      .gpio_ie(gpio_ie), .gpio_data(gpio_data), .gpio_irq(gpio_irq));

   task automatic check(input string what, input logic [PW-1:0] got, input logic [PW-1:0] exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("Some tests failed");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   // Field order from the MSB end
   function automatic logic [PW-1:0] make_pkt(input logic wr, input logic [1:0] dm,
      input logic [4:0] ctl, input logic [31:0] dst, input logic [31:0] src,
      input logic [31:0] data);
      return {src, data, dst, ctl, dm, wr};
   endfunction

   //##################################################
   // Reference model
   //##################################################
   function automatic logic [PW-1:0] ref_response(input logic [3:0] idx,
      input logic [31:0] src, input logic [1:0] dm, input logic [4:0] ctl);
      logic [31:0] val;
      case (idx)
         gpio_pkg::REG_OEN:   val = oen_m[31:0];   // Low half only, N under 32
         gpio_pkg::REG_OUT:   val = out_m[31:0];
         gpio_pkg::REG_IEN:   val = ien_m[31:0];
         gpio_pkg::REG_IN:    val = 32'(gpio_in & ien_m[N-1:0]);
         gpio_pkg::REG_IMASK: val = imask_m[31:0];
         default:             val = 32'h0;
      endcase
      return make_pkt(1'b1, dm, ctl, src, 32'h0, val);  // Back to the sender
   endfunction

   // Single writes, low word only
   task automatic update_model(input logic [3:0] idx, input logic [31:0] wd);
      case (idx)
         gpio_pkg::REG_OEN:    oen_m[31:0] = wd;
         gpio_pkg::REG_OUT:    out_m[31:0] = wd;
         gpio_pkg::REG_IEN:    ien_m[31:0] = wd;
         gpio_pkg::REG_OUTAND: out_m[31:0] = out_m[31:0] & wd;
         gpio_pkg::REG_OUTORR: out_m[31:0] = out_m[31:0] | wd;
         gpio_pkg::REG_OUTXOR: out_m[31:0] = out_m[31:0] ^ wd;
         gpio_pkg::REG_IMASK:  imask_m[31:0] = wd;
         default: ;
      endcase
   endtask

   //##################################################
   // Bus tasks, called 1 ns after a rising edge
   //##################################################
   task automatic send_request(input logic [PW-1:0] pkt);
      while (wait_out) begin  // No new request over a held response
         @(posedge clk);
         #1;
      end
      access_in = 1'b1;
      packet_in = pkt;
      @(posedge clk);
      #1 access_in = 1'b0;
   endtask

   task automatic write_reg(input logic [3:0] idx, input logic [31:0] wd);
      send_request(make_pkt(1'b1, 2'b10, 5'($urandom), {25'h0, idx, 3'b0}, $urandom, wd));
      update_model(idx, wd);
   endtask

   // hold > 0 stalls the response that many cycles
   task automatic read_reg(input logic [3:0] idx, input int hold);
      logic [31:0] src;
      logic [4:0] ctl;
      logic [PW-1:0] held;
      int target;
      src = $urandom;
      ctl = 5'($urandom);
      exp_q.push_back(ref_response(idx, src, 2'b10, ctl));
      target = rsp_count + 1;
      wait_in = (hold > 0);
      send_request(make_pkt(1'b0, 2'b10, ctl, {25'h0, idx, 3'b0}, src, 32'h0));
      if (hold > 0) begin
         @(negedge clk);
         held = packet_out;
         repeat (hold) begin
            check("access_out under wait", PW'(access_out), PW'(1));
            check("wait_out under wait", PW'(wait_out), PW'(1));
            check("packet_out under wait", packet_out, held);
            @(negedge clk);
         end
         @(posedge clk);
         #1 wait_in = 1'b0;
      end
      wait (rsp_count >= target);
      @(posedge clk);
      #1;
   endtask

   task automatic count_irq(input int cycles, output int cnt);
      cnt = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (gpio_irq) cnt++;
      end
      @(posedge clk);
      #1;
   endtask

   // Comparator, one consumed response per cycle
   always @(negedge clk) begin
      if (nreset && access_out && !wait_in) begin
         if (exp_q.size() == 0) begin
            $display("Some tests failed");
            $fatal(1, "A response packet arrived with no read pending");
         end else begin
            check("response packet", packet_out, exp_q.pop_front());
            rsp_count++;
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Some tests failed");
      $fatal(1, "The watchdog expired before the tests finished");
   end

   //##################################################
   // Test sequence
   //##################################################
   initial begin
      logic [3:0] idx;
      int u;
      int m;
      int cnt;
      access_in = 1'b0;
      packet_in = '0;
      wait_in = 1'b0;
      gpio_in = '0;
      void'($urandom(32'h6d8e5b81));
      oen_m = 64'h0;
      out_m = 64'h0;
      ien_m = {64{1'b1}};  // Inputs live out of reset
      imask_m = 64'h0;
      @(posedge nreset);
      @(posedge clk);
      #1;
      // Reset values
      check("gpio_oen reset", PW'(gpio_oen), PW'(0));
      check("gpio_out reset", PW'(gpio_out), PW'(0));
      check("gpio_ie reset", PW'(gpio_ie), PW'({N{1'b1}}));
      read_reg(gpio_pkg::REG_OEN, 0);
      read_reg(gpio_pkg::REG_IEN, 0);
      read_reg(gpio_pkg::REG_IMASK, 0);
      // Output ops
      for (int i = 0; i < NUM_OPS; i++) begin
         case ($urandom % 4)
            0: idx = gpio_pkg::REG_OUT;
            1: idx = gpio_pkg::REG_OUTAND;
            2: idx = gpio_pkg::REG_OUTORR;
            default: idx = gpio_pkg::REG_OUTXOR;
         endcase
         write_reg(idx, $urandom);
         check("gpio_out after op", PW'(gpio_out), PW'(out_m[N-1:0]));
      end
      // Control registers, then the unmapped aliases
      for (int i = 0; i < NUM_REG; i++) begin
         case ($urandom % 3)
            0: idx = gpio_pkg::REG_OEN;
            1: idx = gpio_pkg::REG_IEN;
            default: idx = gpio_pkg::REG_IMASK;
         endcase
         write_reg(idx, $urandom);
         check("gpio_oen after write", PW'(gpio_oen), PW'(oen_m[N-1:0]));
         check("gpio_ie after write", PW'(gpio_ie), PW'(ien_m[N-1:0]));
         read_reg(idx, 0);
      end
      for (int k = 4; k < 16; k++)
         if (k != 7) read_reg(4'(k), 0);
      // Input path
      write_reg(gpio_pkg::REG_IEN, $urandom);
      for (int i = 0; i < NUM_IN; i++) begin
         gpio_in = N'($urandom);
         repeat (4) @(posedge clk);  // Sync plus input register
         #1;
         check("gpio_data", PW'(gpio_data), PW'(gpio_in & ien_m[N-1:0]));
         read_reg(gpio_pkg::REG_IN, 0);
      end
      // Interrupt, one unmasked and one masked pin
      write_reg(gpio_pkg::REG_IEN, 32'hffffffff);
      for (int i = 0; i < NUM_IRQ; i++) begin
         u = $urandom % N;
         m = (u + 1 + $urandom % (N-1)) % N;
         write_reg(gpio_pkg::REG_IMASK, 32'd1 << m);
         count_irq(6, cnt);  // Let mask change settle
         gpio_in[u] = ~gpio_in[u];
         count_irq(5, cnt);
         check("irq pulses, unmasked pin", PW'(cnt), PW'(1));
         count_irq(3, cnt);
         check("irq after the pulse", PW'(cnt), PW'(0));
         gpio_in[m] = ~gpio_in[m];
         count_irq(8, cnt);
         check("irq pulses, masked pin", PW'(cnt), PW'(0));
      end
      // Back-pressure on a read
      read_reg(gpio_pkg::REG_OEN, 6);
      if (i_dut.i_readback.i_props.fail_count != 0) begin
         $display("Some tests failed");
         $fatal(1, "A bound assertion on the response port failed");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// ==== project.f ====
design/emesh_pkg.sv
design/gpio_pkg.sv
design/reg_access_if.sv
design/emesh_decoder.sv
design/gpio_input_stage.sv
design/gpio_regfile.sv
design/emesh_readback.sv
design/gpio.sv
verif/clk_gen.sv
verif/gpio_props.sv
verif/tb_gpio.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gpio
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
